/* files.f */
+incdir+hw
+incdir+tests
hw/fctrlPkg.sv
hw/fpCtrlIf.sv
hw/fpDecodeStage.sv
hw/fpExecuteStage.sv
hw/fpMemWbStage.sv
hw/fctrl.sv
tests/fctrlTb.sv

/* hw/fctrl.sv */
`timescale 1ns/1ps
`include "fctrl_cfg.svh"

module fctrl import fctrlPkg::*; (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     stallE, stallM, stallW,
  input  logic                     flushE, flushM, flushW,
  input  logic                     fDivBusyE,
  input  fsStateE                  statusFs,
  input  roundModeE                frmRegW,
  input  logic [31:0]              instrD,
  // decode
  output logic                     illegalD,
  output logic                     divStartD,
  output logic                     xEnD, yEnD, zEnD,
  output logic [`ADR_WIDTH-1:0]    adr1D, adr2D, adr3D,
  // execute
  output logic [`RM_WIDTH-1:0]     frmE,
  output logic                     fmtE,
  output logic [`OPCTRL_WIDTH-1:0] opCtrlE,
  output logic [1:0]               resSelE,
  output logic [1:0]               postProcSelE,
  output logic                     regWriteE, writeIntE, cvtIntE,
  output logic                     fpuActiveE,
  output logic                     divStartE,
  output logic                     xEnE, yEnE, zEnE,
  output logic [`ADR_WIDTH-1:0]    adr1E, adr2E, adr3E,
  // memory
  output logic [`RM_WIDTH-1:0]     frmM,
  output logic                     fmtM,
  output logic [`OPCTRL_WIDTH-1:0] opCtrlM,
  output logic [1:0]               resSelM,
  output logic [1:0]               postProcSelM,
  output logic                     regWriteM, writeIntM,
  output logic                     fpLoadStoreM,
  // writeback
  output logic                     regWriteW,
  output logic [1:0]               resSelW,
  output logic                     cvtIntW
);

  fpCtrlIf dCtrl ();   // decode -> D/E
  fpCtrlIf eCtrl ();   // D/E -> E/M

  fpDecodeStage decode0 (
    .instrD, .statusFs, .frmRegW, .ctrl(dCtrl.src),
    .divStartD, .illegalD, .xEnD, .yEnD, .zEnD, .adr1D, .adr2D, .adr3D
  );

  fpExecuteStage execute0 (
    .clk, .rstN, .stallE, .flushE, .fDivBusyE, .dCtrl(dCtrl.sink),
    .divStartD, .xEnD, .yEnD, .zEnD, .adr1D, .adr2D, .adr3D,
    .eCtrl(eCtrl.src), .xEnE, .yEnE, .zEnE, .adr1E, .adr2E, .adr3E, .divStartE
  );

  fpMemWbStage memWb0 (
    .clk, .rstN, .stallM, .flushM, .stallW, .flushW, .eCtrl(eCtrl.sink),
    .frmM, .fmtM, .opCtrlM, .resSelM, .postProcSelM, .regWriteM, .writeIntM,
    .fpLoadStoreM, .regWriteW, .resSelW, .cvtIntW
  );

  // E stage unpacked for the datapath
  assign frmE         = eCtrl.frm;
  assign fmtE         = eCtrl.fmt;
  assign opCtrlE      = eCtrl.opCtrl;
  assign resSelE      = eCtrl.resSel;
  assign postProcSelE = eCtrl.postProcSel;
  assign regWriteE    = eCtrl.regWrite;
  assign writeIntE    = eCtrl.writeInt;
  assign cvtIntE      = eCtrl.cvtInt;
  assign fpuActiveE   = eCtrl.active;

endmodule

/* hw/fctrlPkg.sv */
package fctrlPkg;

  `include "fctrl_cfg.svh"

  // major opcodes handled by the fpu
  typedef enum logic [6:0] {
    loadFp  = 7'b0000111,
    storeFp = 7'b0100111,
    madd    = 7'b1000011,
    msub    = 7'b1000111,
    nmsub   = 7'b1001011,
    nmadd   = 7'b1001111,
    opFp    = 7'b1010011
  } fpOpcodeE;

  // final result select, meaning depends on destination
  //   fp dest: other / postproc / store   int dest: cmp / cvt / class / mv
  typedef enum logic [1:0] {
    resOther    = 2'b00,
    resPostProc = 2'b01,
    resStore    = 2'b10,
    resMove     = 2'b11
  } resSelE;

  // post-processing unit select
  typedef enum logic [1:0] {
    ppCvt = 2'b00,
    ppDiv = 2'b01,
    ppFma = 2'b10
  } postProcSelE;

  typedef enum logic [`RM_WIDTH-1:0] {
    rne  = 3'b000,  // nearest, ties to even
    rtz  = 3'b001,
    rdn  = 3'b010,
    rup  = 3'b011,
    rmm  = 3'b100,  // nearest, ties away
    rsv5 = 3'b101,
    rsv6 = 3'b110,
    dyn  = 3'b111   // take frm from csr
  } roundModeE;

  // mstatus.FS
  typedef enum logic [1:0] {
    fsOff     = 2'b00,
    fsInitial = 2'b01,
    fsClean   = 2'b10,
    fsDirty   = 2'b11
  } fsStateE;

endpackage

/* hw/fctrl_cfg.svh */
`ifndef FCTRL_CFG_SVH
`define FCTRL_CFG_SVH

// integer register width, RV32 only
`define XLEN         32
// double precision legal
`define D_SUPPORTED  1'b1

`define RM_WIDTH     3   // rounding mode
`define OPCTRL_WIDTH 3   // per-unit operation select
`define ADR_WIDTH    5   // fp register address
`define TBL_WIDTH    12  // decode table row
`define CTRL_WIDTH   15  // packed stage bundle

// instruction field positions (lsb)
`define F3_LSB       12
`define RS1_LSB      15
`define RS2_LSB      20
`define F7_LSB       25
`define RS3_LSB      27

`endif

/* hw/fpCtrlIf.sv */
`timescale 1ns/1ps
`include "fctrl_cfg.svh"

// decoded fp controls for one pipeline stage
interface fpCtrlIf import fctrlPkg::*; ();

  logic                     regWrite;     // fp regfile write
  logic                     writeInt;     // int regfile write
  resSelE                   resSel;
  postProcSelE              postProcSel;
  logic [`OPCTRL_WIDTH-1:0] opCtrl;
  roundModeE                frm;
  logic                     fmt;          // 1 = double
  logic                     cvtInt;       // fp -> int convert
  logic                     active;       // legal fp op in flight

  // stage that produces the bundle
  modport src (
    output regWrite, writeInt, resSel, postProcSel,
    output opCtrl, frm, fmt, cvtInt, active
  );

  // stage that consumes it
  modport sink (
    input regWrite, writeInt, resSel, postProcSel,
    input opCtrl, frm, fmt, cvtInt, active
  );

endinterface

/* hw/fpDecodeStage.sv */
`timescale 1ns/1ps
`include "fctrl_cfg.svh"

module fpDecodeStage import fctrlPkg::*; (
  input  logic [31:0]           instrD,
  input  fsStateE               statusFs,
  input  roundModeE             frmRegW,     // csr frm
  fpCtrlIf.src                  ctrl,
  output logic                  divStartD,
  output logic                  illegalD,
  output logic                  xEnD, yEnD, zEnD,
  output logic [`ADR_WIDTH-1:0] adr1D, adr2D, adr3D
);

  fpOpcodeE              opD;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [4:0]            rs2;
  logic                  loadStore;
  logic                  fmtOk, rmOk;
  logic                  mvToFp;       // fmv.w.x
  logic [`TBL_WIDTH-1:0] ctl;          // decode table row

  ////////////////////////////////////////////////////////////////////////////
  // instruction fields

  assign opD    = fpOpcodeE'(instrD[6:0]);
  assign funct3 = instrD[`F3_LSB +: 3];
  assign funct7 = instrD[`F7_LSB +: 7];
  assign rs2    = instrD[`RS2_LSB +: 5];

  assign adr1D = instrD[`RS1_LSB +: `ADR_WIDTH];
  assign adr2D = instrD[`RS2_LSB +: `ADR_WIDTH];
  assign adr3D = instrD[`RS3_LSB +: `ADR_WIDTH];   // fma third source

  assign loadStore = (opD == loadFp) || (opD == storeFp);

  // only s and d exist here
  assign fmtOk = (funct7[1:0] == 2'b00) || (funct7[1:0] == 2'b01 && `D_SUPPORTED);

  // 5/6 reserved; dyn is reserved too when csr frm holds 5..7
  assign rmOk = !(funct3 inside {rsv5, rsv6}) && !(funct3 == dyn && frmRegW > rmm);

  ////////////////////////////////////////////////////////////////////////////
  // control table
  // row: regWrite_writeInt_resSel_postProcSel_opCtrl_divStart_cvtInt_legal

  always_comb begin
    ctl = '0;                                                // illegal by default
    if (statusFs != fsOff && (loadStore || (fmtOk && rmOk))) begin
      case (opD)
        loadFp:  if (funct3 == 3'b010 || (funct3 == 3'b011 && `D_SUPPORTED))
                   ctl = `TBL_WIDTH'b1_0_10_00_000_0_0_1;   // flw / fld
        storeFp: if (funct3 == 3'b010 || (funct3 == 3'b011 && `D_SUPPORTED))
                   ctl = `TBL_WIDTH'b0_0_10_00_000_0_0_1;   // fsw / fsd
        madd:    ctl = `TBL_WIDTH'b1_0_01_10_000_0_0_1;
        msub:    ctl = `TBL_WIDTH'b1_0_01_10_001_0_0_1;
        nmsub:   ctl = `TBL_WIDTH'b1_0_01_10_010_0_0_1;
        nmadd:   ctl = `TBL_WIDTH'b1_0_01_10_011_0_0_1;
        opFp: begin
          case (funct7[6:2])
            5'b00000: ctl = `TBL_WIDTH'b1_0_01_10_110_0_0_1;  // fadd
            5'b00001: ctl = `TBL_WIDTH'b1_0_01_10_111_0_0_1;  // fsub
            5'b00010: ctl = `TBL_WIDTH'b1_0_01_10_100_0_0_1;  // fmul
            5'b00011: ctl = `TBL_WIDTH'b1_0_01_01_000_1_0_1;  // fdiv
            5'b01011: if (rs2 == 5'b00000)
                        ctl = `TBL_WIDTH'b1_0_01_01_001_1_0_1; // fsqrt
            5'b00100: if (funct3 inside {3'b000, 3'b001, 3'b010})
                        ctl = {7'b1_0_00_00_0, funct3[1:0], 3'b0_0_1}; // fsgnj/n/x
            5'b00101: begin
              if (funct3 == 3'b000)
                ctl = `TBL_WIDTH'b1_0_00_00_110_0_0_1;        // fmin
              else if (funct3 == 3'b001)
                ctl = `TBL_WIDTH'b1_0_00_00_101_0_0_1;        // fmax
            end
            5'b10100: begin
              if (funct3 == 3'b000)
                ctl = `TBL_WIDTH'b0_1_00_00_011_0_0_1;        // fle
              else if (funct3 == 3'b001)
                ctl = `TBL_WIDTH'b0_1_00_00_001_0_0_1;        // flt
              else if (funct3 == 3'b010)
                ctl = `TBL_WIDTH'b0_1_00_00_010_0_0_1;        // feq
            end
            5'b11100: begin
              if (funct3 == 3'b001 && rs2 == 5'b00000)
                ctl = `TBL_WIDTH'b0_1_10_00_000_0_0_1;        // fclass
              else if (funct3 == 3'b000 && rs2 == 5'b00000 &&
                       (funct7[1:0] == 2'b00 || (`XLEN == 64 && funct7[1:0] == 2'b01)))
                ctl = `TBL_WIDTH'b0_1_11_00_000_0_0_1;        // fmv.x.w
            end
            5'b11110: if (funct3 == 3'b000 && rs2 == 5'b00000 && funct7[1:0] == 2'b00)
                        ctl = `TBL_WIDTH'b1_0_00_00_011_0_0_1; // fmv.w.x
            // fcvt.s.d / fcvt.d.s, opCtrl[0] is the target format
            5'b01000: if (rs2[4:1] == 4'b0000 && rs2[0] != funct7[0] && `D_SUPPORTED)
                        ctl = {8'b1_0_01_00_00, funct7[0], 3'b0_0_1};
            // w/wu -> fp, opCtrl = {int->fp, 64b, signed}
            5'b11010: if (rs2[4:1] == 4'b0000)
                        ctl = {8'b1_0_01_00_10, ~rs2[0], 3'b0_0_1};
            // fp -> w/wu
            5'b11000: if (rs2[4:1] == 4'b0000)
                        ctl = {8'b0_1_01_00_00, ~rs2[0], 3'b0_1_1};
            default:  ctl = '0;
          endcase
        end
        default: ctl = '0;
      endcase
    end
  end

  // unpack the row
  assign ctrl.regWrite    = ctl[11];
  assign ctrl.writeInt    = ctl[10];
  assign ctrl.resSel      = resSelE'(ctl[9:8]);
  assign ctrl.postProcSel = postProcSelE'(ctl[7:6]);
  assign ctrl.opCtrl      = ctl[5:3];
  assign divStartD        = ctl[2];
  assign ctrl.cvtInt      = ctl[1];
  assign illegalD         = ~ctl[0];
  assign ctrl.active      = ctl[0];

  // csr frm on dyn
  assign ctrl.frm = (funct3 == dyn) ? frmRegW : roundModeE'(funct3);

  // fp->fp cvt takes the source format from rs2, loads/stores from funct3
  assign ctrl.fmt = (opD == opFp && funct7[6:2] == 5'b01000) ? rs2[0] :
                    loadStore ? (funct3 == 3'b011) : funct7[0];

  ////////////////////////////////////////////////////////////////////////////
  // operand enables, off means nan/inf on that input is ignored

  assign mvToFp = (ctrl.resSel == resOther) && ctrl.regWrite && (ctrl.opCtrl == 3'b011);

  // x: everything but load/store, fmv.w.x, int->fp
  assign xEnD = ~((ctrl.resSel == resStore && !ctrl.writeInt) || mvToFp ||
                  (ctrl.resSel == resPostProc && ctrl.postProcSel == ppCvt && ctrl.opCtrl[2]));

  // y: off for load, fclass, fmv, cvt, sqrt
  assign yEnD = ~((ctrl.resSel == resStore && (ctrl.writeInt || ctrl.regWrite)) || mvToFp ||
                  (ctrl.resSel == resMove && ctrl.postProcSel == ppCvt) ||
                  (ctrl.resSel == resPostProc && (ctrl.postProcSel == ppCvt ||
                   (ctrl.postProcSel == ppDiv && ctrl.opCtrl[0]))));

  // z: fma family plus add/sub
  assign zEnD = (ctrl.postProcSel == ppFma) && (!ctrl.opCtrl[2] || ctrl.opCtrl[1]);

  // a trapping op must not write back or start the divider
  always_comb begin
    if (illegalD)
      assert (!ctrl.regWrite && !ctrl.writeInt && !divStartD)
        else $error("illegal fp instruction still issues side effects");
  end

endmodule

/* hw/fpExecuteStage.sv */
`timescale 1ns/1ps
`include "fctrl_cfg.svh"

module fpExecuteStage import fctrlPkg::*; (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  stallE,
  input  logic                  flushE,
  input  logic                  fDivBusyE,
  fpCtrlIf.sink                 dCtrl,
  input  logic                  divStartD,
  input  logic                  xEnD, yEnD, zEnD,
  input  logic [`ADR_WIDTH-1:0] adr1D, adr2D, adr3D,
  fpCtrlIf.src                  eCtrl,
  output logic                  xEnE, yEnE, zEnE,
  output logic [`ADR_WIDTH-1:0] adr1E, adr2E, adr3E,
  output logic                  divStartE
);

  logic [`CTRL_WIDTH-1:0] ctrlQ;   // packed D/E bundle

  ////////////////////////////////////////////////////////////////////////////
  // D/E register, flush wins over stall

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN || flushE) begin
      ctrlQ                 <= '0;
      {xEnE, yEnE, zEnE}    <= '0;
      {adr1E, adr2E, adr3E} <= '0;
    end else if (!stallE) begin
      ctrlQ <= {dCtrl.regWrite, dCtrl.writeInt, dCtrl.resSel, dCtrl.postProcSel,
                dCtrl.opCtrl, dCtrl.frm, dCtrl.fmt, dCtrl.cvtInt, dCtrl.active};
      {xEnE, yEnE, zEnE}    <= {xEnD, yEnD, zEnD};
      {adr1E, adr2E, adr3E} <= {adr1D, adr2D, adr3D};
    end
  end

  // keeps loading while the divider is busy so the start is not lost
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      divStartE <= 1'b0;
    else if (flushE)
      divStartE <= 1'b0;
    else if (!stallE || fDivBusyE)
      divStartE <= divStartD;
  end

  assign eCtrl.regWrite    = ctrlQ[14];
  assign eCtrl.writeInt    = ctrlQ[13];
  assign eCtrl.resSel      = resSelE'(ctrlQ[12:11]);
  assign eCtrl.postProcSel = postProcSelE'(ctrlQ[10:9]);
  assign eCtrl.opCtrl      = ctrlQ[8:6];
  assign eCtrl.frm         = roundModeE'(ctrlQ[5:3]);
  assign eCtrl.fmt         = ctrlQ[2];
  assign eCtrl.cvtInt      = ctrlQ[1];
  assign eCtrl.active      = ctrlQ[0];

  // divider start only alongside a div/sqrt in E
  assert property (@(posedge clk) disable iff (!rstN)
    divStartE |-> eCtrl.postProcSel == ppDiv)
    else $error("divider start without div/sqrt in E");

endmodule

/* hw/fpMemWbStage.sv */
`timescale 1ns/1ps
`include "fctrl_cfg.svh"

module fpMemWbStage import fctrlPkg::*; (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     stallM, flushM,
  input  logic                     stallW, flushW,
  fpCtrlIf.sink                    eCtrl,
  output roundModeE                frmM,
  output logic                     fmtM,
  output logic [`OPCTRL_WIDTH-1:0] opCtrlM,
  output resSelE                   resSelM,
  output postProcSelE              postProcSelM,
  output logic                     regWriteM,
  output logic                     writeIntM,
  output logic                     fpLoadStoreM,
  output logic                     regWriteW,
  output resSelE                   resSelW,
  output logic                     cvtIntW
);

  logic [13:0] emQ;     // E/M bundle
  logic [3:0]  mwQ;     // M/W bundle, results finishing in W
  logic        cvtIntM;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN || flushM)
      emQ <= '0;
    else if (!stallM)
      emQ <= {eCtrl.regWrite, eCtrl.writeInt, eCtrl.resSel, eCtrl.postProcSel,
              eCtrl.opCtrl, eCtrl.frm, eCtrl.fmt, eCtrl.cvtInt};
  end

  assign {regWriteM, writeIntM} = emQ[13:12];
  assign resSelM                = resSelE'(emQ[11:10]);
  assign postProcSelM           = postProcSelE'(emQ[9:8]);
  assign opCtrlM                = emQ[7:5];
  assign frmM                   = roundModeE'(emQ[4:2]);
  assign {fmtM, cvtIntM}        = emQ[1:0];

  assign fpLoadStoreM = resSelM[1];   // store/class code, load or store in M

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN || flushW)
      mwQ <= '0;
    else if (!stallW)
      mwQ <= {regWriteM, resSelM, cvtIntM};
  end

  assign regWriteW = mwQ[3];
  assign resSelW   = resSelE'(mwQ[2:1]);
  assign cvtIntW   = mwQ[0];

  // one destination regfile per op
  assert property (@(posedge clk) disable iff (!rstN) !(writeIntM && regWriteM))
    else $error("fp op writes both register files in M");

endmodule

/* run.sh */
#!/bin/sh
# build and run the fctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module fctrlTb \
  -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

/* tests/fctrlTbTasks.svh */
// expected decode per instruction class
// row: opcode, funct7, rs2, funct3, {rmFree, dblOk, rs2Free},
//      {regWrite, writeInt, resSel, ppSel, opCtrl, divStart, cvtInt, xEn, yEn, zEn}
localparam int numClasses = 30;
localparam logic [38:0] classSpec [0:29] = '{
  {7'b0000111, 7'b0000000, 5'd0, 3'b010, 3'b001, 14'b1_0_10_00_000_0_0_0_0_0},  // flw
  {7'b0000111, 7'b0000000, 5'd0, 3'b011, 3'b001, 14'b1_0_10_00_000_0_0_0_0_0},  // fld
  {7'b0100111, 7'b0000000, 5'd0, 3'b010, 3'b001, 14'b0_0_10_00_000_0_0_0_1_0},  // fsw
  {7'b0100111, 7'b0000000, 5'd0, 3'b011, 3'b001, 14'b0_0_10_00_000_0_0_0_1_0},  // fsd
  {7'b1000011, 7'b0000000, 5'd0, 3'b000, 3'b111, 14'b1_0_01_10_000_0_0_1_1_1},  // fmadd
  {7'b1000111, 7'b0000000, 5'd0, 3'b000, 3'b111, 14'b1_0_01_10_001_0_0_1_1_1},  // fmsub
  {7'b1001011, 7'b0000000, 5'd0, 3'b000, 3'b111, 14'b1_0_01_10_010_0_0_1_1_1},  // fnmsub
  {7'b1001111, 7'b0000000, 5'd0, 3'b000, 3'b111, 14'b1_0_01_10_011_0_0_1_1_1},  // fnmadd
  {7'b1010011, 7'b0000000, 5'd0, 3'b000, 3'b111, 14'b1_0_01_10_110_0_0_1_1_1},  // fadd
  {7'b1010011, 7'b0000100, 5'd0, 3'b000, 3'b111, 14'b1_0_01_10_111_0_0_1_1_1},  // fsub
  {7'b1010011, 7'b0001000, 5'd0, 3'b000, 3'b111, 14'b1_0_01_10_100_0_0_1_1_0},  // fmul
  {7'b1010011, 7'b0001100, 5'd0, 3'b000, 3'b111, 14'b1_0_01_01_000_1_0_1_1_0},  // fdiv
  {7'b1010011, 7'b0101100, 5'd0, 3'b000, 3'b110, 14'b1_0_01_01_001_1_0_1_0_0},  // fsqrt
  {7'b1010011, 7'b0010000, 5'd0, 3'b000, 3'b011, 14'b1_0_00_00_000_0_0_1_1_0},  // fsgnj
  {7'b1010011, 7'b0010000, 5'd0, 3'b001, 3'b011, 14'b1_0_00_00_001_0_0_1_1_0},  // fsgnjn
  {7'b1010011, 7'b0010000, 5'd0, 3'b010, 3'b011, 14'b1_0_00_00_010_0_0_1_1_0},  // fsgnjx
  {7'b1010011, 7'b0010100, 5'd0, 3'b000, 3'b011, 14'b1_0_00_00_110_0_0_1_1_0},  // fmin
  {7'b1010011, 7'b0010100, 5'd0, 3'b001, 3'b011, 14'b1_0_00_00_101_0_0_1_1_0},  // fmax
  {7'b1010011, 7'b1010000, 5'd0, 3'b000, 3'b011, 14'b0_1_00_00_011_0_0_1_1_0},  // fle
  {7'b1010011, 7'b1010000, 5'd0, 3'b001, 3'b011, 14'b0_1_00_00_001_0_0_1_1_0},  // flt
  {7'b1010011, 7'b1010000, 5'd0, 3'b010, 3'b011, 14'b0_1_00_00_010_0_0_1_1_0},  // feq
  {7'b1010011, 7'b1110000, 5'd0, 3'b001, 3'b010, 14'b0_1_10_00_000_0_0_1_0_0},  // fclass
  {7'b1010011, 7'b1110000, 5'd0, 3'b000, 3'b000, 14'b0_1_11_00_000_0_0_1_0_0},  // fmv.x.w
  {7'b1010011, 7'b1111000, 5'd0, 3'b000, 3'b000, 14'b1_0_00_00_011_0_0_0_0_0},  // fmv.w.x
  {7'b1010011, 7'b0100000, 5'd1, 3'b000, 3'b100, 14'b1_0_01_00_000_0_0_1_0_0},  // fcvt.s.d
  {7'b1010011, 7'b0100001, 5'd0, 3'b000, 3'b100, 14'b1_0_01_00_001_0_0_1_0_0},  // fcvt.d.s
  {7'b1010011, 7'b1100000, 5'd0, 3'b000, 3'b110, 14'b0_1_01_00_001_0_1_1_0_0},  // fcvt.w.s
  {7'b1010011, 7'b1100000, 5'd1, 3'b000, 3'b110, 14'b0_1_01_00_000_0_1_1_0_0},  // fcvt.wu.s
  {7'b1010011, 7'b1101000, 5'd0, 3'b000, 3'b110, 14'b1_0_01_00_101_0_0_0_0_0},  // fcvt.s.w
  {7'b1010011, 7'b1101000, 5'd1, 3'b000, 3'b110, 14'b1_0_01_00_100_0_0_0_0_0}   // fcvt.s.wu
};

function automatic logic [31:0] nextRand();
  seed = seed * 32'd1664525 + 32'd1013904223;
  return seed;
endfunction

// R4/R-type layout, rd in [11:7]
function automatic logic [31:0] asm(input logic [6:0] op, input logic [6:0] f7,
                                    input logic [4:0] rs2, input logic [2:0] f3,
                                    input logic [4:0] rs1, input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, op};
endfunction

// regs = {rd, rs3, rs2, rs1}
function automatic logic [31:0] makeInstr(input int cls, input logic dbl,
                                          input logic [2:0] rm, input logic [19:0] regs);
  logic [38:0] row;
  logic [6:0]  f7;
  logic [4:0]  rs2;
  logic [2:0]  f3;
  row = classSpec[cls];
  f7  = row[31:25];
  rs2 = row[24:20];
  f3  = row[19:17];
  if (row[16]) f3 = rm;
  if (row[15] && dbl) f7[0] = 1'b1;
  if (row[14]) rs2 = regs[9:5];
  if (row[38:36] == 3'b100) f7[6:2] = regs[14:10];   // fma rs3
  return asm(row[38:32], f7, rs2, f3, regs[4:0], regs[19:15]);
endfunction

// format asked for by class and dbl, fp->fp cvt reports its source
function automatic logic expectedFmt(input int cls, input logic dbl);
  case (cls)
    1, 3:    return 1'b1;              // fld, fsd
    24:      return 1'b1;              // fcvt.s.d reads a double
    25:      return 1'b0;              // fcvt.d.s reads a single
    default: return dbl && classSpec[cls][15];
  endcase
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  assert (got === exp) else begin
    $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
    errors++;
  end
endtask

task automatic endTest(input string name, input int errBefore);
  tests++;
  $display("%-14s done, %0d errors", name, errors - errBefore);
endtask

////////////////////////////////////////////////////////////////////////////
// drive one instruction, D checked at negedge, E just after the next edge
// entered and left 2 ns past a rising edge

// expRmFmt = {frm, fmt}
task automatic applyCheck(input logic [31:0] ins, input logic legal,
                          input logic [13:0] exp, input logic [3:0] expRmFmt);
  instrD = ins;
  @(negedge clk);
  check("illegalD", illegalD, !legal);
  check("divStartD", divStartD, exp[4]);
  check("adr1D/2D/3D", {adr1D, adr2D, adr3D}, {ins[19:15], ins[24:20], ins[31:27]});
  if (legal) check("xEnD/yEnD/zEnD", {xEnD, yEnD, zEnD}, exp[2:0]);
  @(posedge clk);
  #1;
  check("regWr/wrInt/resSel/ppSel/opCtrl/divStart/cvtInt E",
        {regWriteE, writeIntE, resSelEOut, ppSelE, opCtrlE, divStartE, cvtIntE}, exp[13:3]);
  check("fpuActiveE", fpuActiveE, legal);
  check("adr1E/2E/3E", {adr1E, adr2E, adr3E}, {ins[19:15], ins[24:20], ins[31:27]});
  if (legal) begin
    check("frmE", frmE, expRmFmt[3:1]);
    check("fmtE", fmtE, expRmFmt[0]);
    check("xEnE/yEnE/zEnE", {xEnE, yEnE, zEnE}, exp[2:0]);
  end
  #1;
endtask

task automatic resetTest();
  int e0;
  e0 = errors;
  check("fpuActiveE", fpuActiveE, 1'b0);
  check("divStartE", divStartE, 1'b0);
  check("regWriteE/M/W", {regWriteE, regWriteM, regWriteW}, 3'b000);
  check("resSelE", resSelEOut, 2'b00);
  check("frmE", frmE, 3'b000);
  endTest("reset", e0);
endtask

// every class, single and double where legal, rm incl dyn
task automatic decodeSweep();
  int          e0;
  logic [31:0] r;
  logic [2:0]  rm;
  logic [2:0]  rmExp;
  e0 = errors;
  for (int cls = 0; cls < numClasses; cls++) begin
    for (int d = 0; d < 2; d++) begin
      if (d == 0 || classSpec[cls][15]) begin
        r  = nextRand();
        rm = (r[2:0] > 3'd4) ? 3'd7 : r[2:0];
        frmRegW = roundModeE'((r[5:3] > 3'd4) ? 3'd0 : r[5:3]);
        if (!classSpec[cls][16])
          rmExp = classSpec[cls][19:17];   // fixed funct3
        else if (rm == 3'd7)
          rmExp = frmRegW;
        else
          rmExp = rm;
        applyCheck(makeInstr(cls, d[0], rm, r[31:12]), 1'b1, classSpec[cls][13:0],
                   {rmExp, expectedFmt(cls, d[0])});
      end
    end
  end
  endTest("decodeSweep", e0);
endtask

task automatic illegalTest();
  int          e0;
  logic [31:0] ins;
  e0 = errors;
  statusFs = fsOff;
  applyCheck(makeInstr(8, 1'b0, 3'd0, 20'h1a2b3), 1'b0, '0, '0);
  applyCheck(makeInstr(0, 1'b0, 3'd0, 20'h4c5d6), 1'b0, '0, '0);
  statusFs = fsDirty;
  applyCheck(makeInstr(8, 1'b0, 3'd5, 20'h12345), 1'b0, '0, '0);   // reserved rm
  applyCheck(makeInstr(8, 1'b0, 3'd6, 20'h12345), 1'b0, '0, '0);
  for (int v = 5; v < 8; v++) begin
    frmRegW = roundModeE'(v[2:0]);                                   // bad csr frm
    applyCheck(makeInstr(8, 1'b0, 3'd7, 20'h6789a), 1'b0, '0, '0);
  end
  frmRegW = rne;
  ins = makeInstr(8, 1'b0, 3'd0, 20'h2468a);
  ins[26:25] = 2'b11;                  // quad
  applyCheck(ins, 1'b0, '0, '0);
  ins[26:25] = 2'b10;                  // half
  applyCheck(ins, 1'b0, '0, '0);
  ins = makeInstr(12, 1'b0, 3'd0, 20'h13579);
  ins[20] = 1'b1;                      // fsqrt rs2 != 0
  applyCheck(ins, 1'b0, '0, '0);
  ins = makeInstr(0, 1'b0, 3'd0, 20'h0f0f0);
  ins[14:12] = 3'd5;                   // no such load width
  applyCheck(ins, 1'b0, '0, '0);
  endTest("illegal", e0);
endtask

task automatic pipelineTest();
  int e0;
  e0 = errors;
  applyCheck(makeInstr(11, 1'b0, 3'd0, 20'h11111), 1'b1, classSpec[11][13:0],
             {3'd0, expectedFmt(11, 1'b0)});
  stallE    = 1'b1;                    // E holds fdiv, divider busy
  fDivBusyE = 1'b1;
  instrD    = makeInstr(8, 1'b0, 3'd0, 20'h22222);
  @(posedge clk);
  #1;
  check("regWriteE/ppSelE/opCtrlE", {regWriteE, ppSelE, opCtrlE}, 6'b1_01_000);
  check("divStartE", divStartE, 1'b0);   // reloaded from D while busy
  #1;
  stallE    = 1'b0;
  fDivBusyE = 1'b0;
  instrD    = makeInstr(26, 1'b0, 3'd0, 20'h33333);
  @(posedge clk);
  #1;
  check("regWriteM", regWriteM, 1'b1);   // fdiv reached M
  #1;
  flushM = 1'b1;
  @(posedge clk);
  #1;
  check("regWr/wrInt/resSel/ppSel/opCtrl/frm/fmt M",
        {regWriteM, writeIntM, resSelM, postProcSelM, opCtrlM, frmM, fmtM}, '0);
  #1;
  flushM = 1'b0;
  endTest("stallFlush", e0);
endtask

// back to back stream, W checked against a 3 deep queue
// entry = {regWrite, resSel, cvtInt}
task automatic streamTest();
  int          e0;
  int          cls;
  logic [31:0] r;
  logic [2:0]  rm;
  logic [3:0]  expW;
  logic [3:0]  q [$];
  e0 = errors;
  frmRegW = rup;
  for (int i = 0; i < 43; i++) begin
    @(posedge clk);
    #1;
    if (q.size() == 3) begin
      expW = q.pop_front();
      check("regWriteW/resSelW/cvtIntW", {regWriteW, resSelW, cvtIntW}, expW);
    end
    if (q.size() == 2)
      check("fpLoadStoreM", fpLoadStoreM, q[0][2]);   // upper resSel bit in M
    #1;
    if (i < 40) begin
      r   = nextRand();
      cls = int'(r[15:0] % 16'd30);
      rm  = (r[18:16] > 3'd4) ? 3'd7 : r[18:16];
      instrD = makeInstr(cls, r[19], rm, r[31:12]);
      q.push_back({classSpec[cls][13], classSpec[cls][11:10], classSpec[cls][3]});
    end else begin
      instrD = '0;                     // drain with illegal slots
      q.push_back(4'b0000);
    end
  end
  endTest("stream", e0);
endtask

/* tests/fctrlTb.sv */
`timescale 1ns/1ps

module fctrlTb import fctrlPkg::*; ();

  logic        clk, rstN;
  logic        stallE, stallM, stallW;
  logic        flushE, flushM, flushW;
  logic        fDivBusyE;
  fsStateE     statusFs;
  roundModeE   frmRegW;
  logic [31:0] instrD;

  // decode outputs
  logic        illegalD, divStartD;
  logic        xEnD, yEnD, zEnD;
  logic [4:0]  adr1D, adr2D, adr3D;
  // execute outputs
  logic [2:0]  frmE, opCtrlE;
  logic        fmtE;
  logic [1:0]  resSelEOut, ppSelE;     // E result and post-proc select
  logic        regWriteE, writeIntE, cvtIntE, fpuActiveE, divStartE;
  logic        xEnE, yEnE, zEnE;
  logic [4:0]  adr1E, adr2E, adr3E;
  // memory and writeback outputs
  logic [2:0]  frmM, opCtrlM;
  logic        fmtM;
  logic [1:0]  resSelM, postProcSelM;
  logic        regWriteM, writeIntM, fpLoadStoreM;
  logic        regWriteW, cvtIntW;
  logic [1:0]  resSelW;

  int          errors, checks, tests;
  logic [31:0] seed;                   // lcg state

  fctrl dut0 (.*, .resSelE(resSelEOut), .postProcSelE(ppSelE));

  always #10 clk = ~clk;

  `include "fctrlTbTasks.svh"

  // hard stop in case a test never returns
  initial begin
    #100us;
    $display("timeout, the test sequence did not finish");
    $display("TB FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    clk       = 1'b0;
    rstN      = 1'b0;
    {stallE, stallM, stallW} = '0;
    {flushE, flushM, flushW} = '0;
    fDivBusyE = 1'b0;
    statusFs  = fsDirty;
    frmRegW   = rne;
    instrD    = '0;                    // opcode 0, never legal
    errors    = 0;
    checks    = 0;
    tests     = 0;
    seed      = 32'd37;

    repeat (10) @(posedge clk);
    #2 rstN = 1'b1;                    // now 2 ns past an edge

    resetTest();
    decodeSweep();
    illegalTest();
    pipelineTest();
    streamTest();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule
